// ==== rename_pkg.sv ====
/*
 * Register-rename sizing defaults and the map read-port layout.
 * Imported by the rename pipeline modules and the top level.
 */
package rename_pkg;

    // ------------------------------------------------------------
    // default register counts, overridden from the top level
    localparam int DEF_AR_COUNT = 32;
    localparam int DEF_PR_COUNT = 64;

    // index widths for the default counts
    localparam int DEF_AR_W = $clog2(DEF_AR_COUNT);
    localparam int DEF_PR_W = $clog2(DEF_PR_COUNT);

    // ------------------------------------------------------------
    // map read ports used per renamed request
    localparam int RD_PORTS = 3;
    localparam int RD_SRC1  = 0;
    localparam int RD_SRC2  = 1;
    // old mapping of the destination
    localparam int RD_DEST  = 2;

endpackage

// ==== apb_map_pkg.sv ====
/*
 * APB control-port register map and command codes for the checkpoint slave.
 */
package apb_map_pkg;

    // data and address width
    localparam int APB_DW = 32;

    // register addresses
    localparam logic [APB_DW-1:0] ADDR_CMD        = 32'h0;
    localparam logic [APB_DW-1:0] ADDR_FREE_COUNT = 32'h4;
    // bit 0 set while a checkpoint is held
    localparam logic [APB_DW-1:0] ADDR_STATUS     = 32'h8;

    // command codes written to ADDR_CMD
    localparam logic [APB_DW-1:0] CMD_SAVE    = 32'd1;
    localparam logic [APB_DW-1:0] CMD_RESTORE = 32'd2;

endpackage

// ==== rename_stage_if.sv ====
/*
 * Valid/ready link carrying one request from the alloc stage to the map stage.
 */
`timescale 1ns/1ps

interface rename_stage_if import rename_pkg::*; #(
    parameter int AR_COUNT = DEF_AR_COUNT,
    parameter int PR_COUNT = DEF_PR_COUNT
);

    localparam int AR_W = $clog2(AR_COUNT);
    localparam int PR_W = $clog2(PR_COUNT);

    // handshake
    logic valid;
    logic ready;

    // request fields plus the PR taken at alloc
    logic [AR_W-1:0] src1_ar;
    logic [AR_W-1:0] src2_ar;
    logic [AR_W-1:0] dest_ar;
    logic            has_dest;
    logic [PR_W-1:0] new_pr;

    modport producer (output valid, src1_ar, src2_ar, dest_ar, has_dest, new_pr, input ready);
    modport consumer (input valid, src1_ar, src2_ar, dest_ar, has_dest, new_pr, output ready);

endinterface

// ==== free_list.sv ====
/*
 * Circular FIFO of free physical registers.
 * Pops at alloc, pushes on commit, head pointer can be saved and restored.
 */
`timescale 1ns/1ps

module free_list import rename_pkg::*; #(
    parameter int AR_COUNT = DEF_AR_COUNT,
    parameter int PR_COUNT = DEF_PR_COUNT,
    localparam int PR_W = $clog2(PR_COUNT),
    localparam int PTR_W = PR_W + 1
) (
    input  logic             CLK,
    input  logic             nRST,
    // alloc side
    input  logic             pop,
    output logic [PR_W-1:0]  pop_pr,
    output logic             empty,
    // commit side
    input  logic             push,
    input  logic [PR_W-1:0]  push_pr,
    // status and checkpoint
    output logic [PTR_W-1:0] count,
    output logic [PTR_W-1:0] head,
    input  logic             restore_valid,
    input  logic [PTR_W-1:0] restore_head
);

    // PRs not mapped after reset
    localparam int FREE_INIT = PR_COUNT - AR_COUNT;

    // ------------------------------------------------------------
    // storage and pointers
    // depth PR_COUNT leaves slack for a restore after commits
    logic [PR_W-1:0]  fifo [PR_COUNT];
    logic [PTR_W-1:0] head_q;
    logic [PTR_W-1:0] tail_q;
    logic             full;

    // extra pointer bit tells full from empty
    assign count  = tail_q - head_q;
    assign empty  = (count == '0);
    assign full   = (count == PTR_W'(PR_COUNT));
    assign head   = head_q;
    assign pop_pr = fifo[head_q[PR_W-1:0]];

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            // AR_COUNT .. PR_COUNT-1 queued in order
            for (int i = 0; i < PR_COUNT; i++) begin
                fifo[i] <= (i < FREE_INIT) ? PR_W'(AR_COUNT + i) : '0;
            end
            head_q <= '0;
            tail_q <= PTR_W'(FREE_INIT);
        end else begin
            if (push) begin
                fifo[tail_q[PR_W-1:0]] <= push_pr;
                tail_q <= tail_q + 1'b1;
            end
            // moving head back reclaims PRs taken since the save
            if (restore_valid) begin
                head_q <= restore_head;
            end else if (pop) begin
                head_q <= head_q + 1'b1;
            end
        end
    end

    // ------------------------------------------------------------
    // alloc must check empty, commit source must respect capacity
    a_no_pop_empty: assert property (@(posedge CLK) disable iff (!nRST)
        pop |-> !empty);
    a_no_push_full: assert property (@(posedge CLK) disable iff (!nRST)
        push |-> !full);

endmodule

// ==== map_table.sv ====
/*
 * Architectural-to-physical register map with three read ports, one write port
 * and a full-table snapshot for checkpointing.
 */
`timescale 1ns/1ps

module map_table import rename_pkg::*; #(
    parameter int AR_COUNT = DEF_AR_COUNT,
    parameter int PR_COUNT = DEF_PR_COUNT,
    localparam int AR_W = $clog2(AR_COUNT),
    localparam int PR_W = $clog2(PR_COUNT)
) (
    input  logic                               CLK,
    input  logic                               nRST,
    // reads
    input  logic [RD_PORTS-1:0][AR_W-1:0]      rd_ar,
    output logic [RD_PORTS-1:0][PR_W-1:0]      rd_pr,
    // write
    input  logic                               wr_valid,
    input  logic [AR_W-1:0]                    wr_ar,
    input  logic [PR_W-1:0]                    wr_pr,
    // checkpoint
    output logic [AR_COUNT-1:0][PR_W-1:0]      save_map,
    input  logic                               restore_valid,
    input  logic [AR_COUNT-1:0][PR_W-1:0]      restore_map
);

    logic [AR_COUNT-1:0][PR_W-1:0] map_q;
    logic [AR_COUNT-1:0][PR_W-1:0] map_next;

    // reads see the registered table only
    always_comb begin
        for (int p = 0; p < RD_PORTS; p++) begin
            rd_pr[p] = map_q[rd_ar[p]];
        end
    end

    // table with this cycle's write folded in
    always_comb begin
        map_next = map_q;
        if (wr_valid) begin
            map_next[wr_ar] = wr_pr;
        end
    end

    // snapshot includes the current write
    assign save_map = map_next;

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            // identity mapping
            for (int ar = 0; ar < AR_COUNT; ar++) begin
                map_q[ar] <= PR_W'(ar);
            end
        end else if (restore_valid) begin
            map_q <= restore_map;
        end else begin
            map_q <= map_next;
        end
    end

    // ------------------------------------------------------------
    // indices from the stage must address real entries
    for (genvar p = 0; p < RD_PORTS; p++) begin : g_rd_range
        a_rd_range: assert property (@(posedge CLK) disable iff (!nRST)
            rd_ar[p] < AR_COUNT);
    end
    a_wr_range: assert property (@(posedge CLK) disable iff (!nRST)
        wr_valid |-> (wr_ar < AR_COUNT));

endmodule

// ==== checkpoint_store.sv ====
/*
 * Single-slot snapshot register for any payload type.
 * Used once for the map table and once for the free-list head.
 */
`timescale 1ns/1ps

module checkpoint_store #(
    parameter type T = logic
) (
    input  logic CLK,
    input  logic nRST,
    input  logic save,
    input  T     save_data,
    output T     data,
    output logic valid
);

    T     data_q;
    logic valid_q;

    assign data  = data_q;
    assign valid = valid_q;

    // slot flag, set by the first save and kept
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            valid_q <= 1'b0;
        end else if (save) begin
            valid_q <= 1'b1;
        end
    end

    // snapshot payload
    always_ff @(posedge CLK) begin
        if (save) begin
            data_q <= save_data;
        end
    end

endmodule

// ==== alloc_stage.sv ====
/*
 * Alloc stage of the rename pipeline. Accepts a request, pops a free PR
 * when the request writes a destination, and forwards both to the map stage.
 */
`timescale 1ns/1ps

module alloc_stage import rename_pkg::*; #(
    parameter int AR_COUNT = DEF_AR_COUNT,
    parameter int PR_COUNT = DEF_PR_COUNT,
    localparam int AR_W = $clog2(AR_COUNT),
    localparam int PR_W = $clog2(PR_COUNT),
    localparam int PTR_W = PR_W + 1
) (
    input  logic                    CLK,
    input  logic                    nRST,
    // rename input stream
    input  logic                    in_valid,
    output logic                    in_ready,
    input  logic [AR_W-1:0]         in_src1_ar,
    input  logic [AR_W-1:0]         in_src2_ar,
    input  logic [AR_W-1:0]         in_dest_ar,
    input  logic                    in_has_dest,
    // checkpoint control
    input  logic                    hold,
    input  logic                    flush,
    // commit port
    input  logic                    commit_valid,
    input  logic [PR_W-1:0]         commit_pr,
    // free-list status and restore
    output logic [PTR_W-1:0]        free_count,
    output logic [PTR_W-1:0]        head,
    input  logic                    restore_valid,
    input  logic [PTR_W-1:0]        restore_head,
    rename_stage_if.producer        st,
    output logic                    busy
);

    logic            room;
    logic            accept;
    logic            pop;
    logic            empty;
    logic [PR_W-1:0] pop_pr;

    free_list #(.AR_COUNT(AR_COUNT), .PR_COUNT(PR_COUNT)) u_free_list (
        .CLK(CLK), .nRST(nRST),
        .pop(pop), .pop_pr(pop_pr), .empty(empty),
        .push(commit_valid), .push_pr(commit_pr),
        .count(free_count), .head(head),
        .restore_valid(restore_valid), .restore_head(restore_head)
    );

    // ------------------------------------------------------------
    // accept when not held, register free or draining,
    // and a PR on hand if the request needs one
    assign room     = !st.valid || st.ready;
    assign in_ready = !hold && room && (!in_has_dest || !empty);
    assign accept   = in_valid && in_ready;
    assign pop      = accept && in_has_dest;
    assign busy     = st.valid;

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            st.valid <= 1'b0;
        end else if (flush) begin
            st.valid <= 1'b0;
        end else if (accept) begin
            st.valid <= 1'b1;
        end else if (st.ready) begin
            st.valid <= 1'b0;
        end
    end

    // request payload with its new PR
    always_ff @(posedge CLK) begin
        if (accept) begin
            st.src1_ar  <= in_src1_ar;
            st.src2_ar  <= in_src2_ar;
            st.dest_ar  <= in_dest_ar;
            st.has_dest <= in_has_dest;
            st.new_pr   <= in_has_dest ? pop_pr : '0;
        end
    end

endmodule

// ==== map_stage.sv ====
/*
 * Map stage of the rename pipeline. Looks up both sources and the old
 * destination mapping, writes the new mapping and holds the result for output.
 */
`timescale 1ns/1ps

module map_stage import rename_pkg::*; #(
    parameter int AR_COUNT = DEF_AR_COUNT,
    parameter int PR_COUNT = DEF_PR_COUNT,
    localparam int AR_W = $clog2(AR_COUNT),
    localparam int PR_W = $clog2(PR_COUNT)
) (
    input  logic                          CLK,
    input  logic                          nRST,
    rename_stage_if.consumer              st,
    // rename output stream
    output logic                          out_valid,
    input  logic                          out_ready,
    output logic [PR_W-1:0]               out_src1_pr,
    output logic [PR_W-1:0]               out_src2_pr,
    output logic [PR_W-1:0]               out_new_pr,
    output logic [PR_W-1:0]               out_old_pr,
    output logic                          out_has_dest,
    // checkpoint
    input  logic                          flush,
    output logic [AR_COUNT-1:0][PR_W-1:0] save_map,
    input  logic                          restore_valid,
    input  logic [AR_COUNT-1:0][PR_W-1:0] restore_map,
    output logic                          busy
);

    logic                          load;
    logic [RD_PORTS-1:0][AR_W-1:0] rd_ar;
    logic [RD_PORTS-1:0][PR_W-1:0] rd_pr;

    // output register free or being taken
    assign st.ready = !out_valid || out_ready;
    assign load     = st.valid && st.ready;
    assign busy     = out_valid;

    always_comb begin
        rd_ar[RD_SRC1] = st.src1_ar;
        rd_ar[RD_SRC2] = st.src2_ar;
        rd_ar[RD_DEST] = st.dest_ar;
    end

    // write lands with the output load, next item sees it
    map_table #(.AR_COUNT(AR_COUNT), .PR_COUNT(PR_COUNT)) u_map_table (
        .CLK(CLK), .nRST(nRST),
        .rd_ar(rd_ar), .rd_pr(rd_pr),
        .wr_valid(load && st.has_dest), .wr_ar(st.dest_ar), .wr_pr(st.new_pr),
        .save_map(save_map),
        .restore_valid(restore_valid), .restore_map(restore_map)
    );

    // ------------------------------------------------------------
    // output register
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            out_valid <= 1'b0;
        end else if (flush) begin
            out_valid <= 1'b0;
        end else if (load) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge CLK) begin
        if (load) begin
            out_src1_pr  <= rd_pr[RD_SRC1];
            out_src2_pr  <= rd_pr[RD_SRC2];
            out_old_pr   <= rd_pr[RD_DEST];
            out_new_pr   <= st.new_pr;
            out_has_dest <= st.has_dest;
        end
    end

    // stalled output holds its values
    a_out_stable: assert property (@(posedge CLK) disable iff (!nRST)
        out_valid && !out_ready && !flush |=> out_valid
        && $stable({out_src1_pr, out_src2_pr, out_new_pr, out_old_pr, out_has_dest}));

endmodule

// ==== apb_ctrl.sv ====
/*
 * APB3 slave for checkpoint save/restore and free-count status.
 * A command write stalls with PREADY low until the pipeline drains and acts.
 */
`timescale 1ns/1ps

module apb_ctrl import rename_pkg::*, apb_map_pkg::*; #(
    parameter int PR_COUNT = DEF_PR_COUNT,
    localparam int PTR_W = $clog2(PR_COUNT) + 1
) (
    input  logic              CLK,
    input  logic              nRST,
    // APB
    input  logic              PSEL,
    input  logic              PENABLE,
    input  logic              PWRITE,
    input  logic [APB_DW-1:0] PADDR,
    input  logic [APB_DW-1:0] PWDATA,
    output logic [APB_DW-1:0] PRDATA,
    output logic              PREADY,
    output logic              PSLVERR,
    // status in
    input  logic [PTR_W-1:0]  free_count,
    input  logic              ckpt_valid,
    input  logic              pipe_busy,
    // checkpoint control out
    output logic              ckpt_hold,
    output logic              ckpt_save,
    output logic              ckpt_restore
);

    typedef enum logic [1:0] {S_IDLE, S_DRAIN, S_ACT, S_DONE} state_t;

    state_t state_q;
    state_t state_d;
    logic   op_restore_q;
    logic   access;
    logic   cmd_wr;
    logic   cmd_ok;
    logic   addr_ok;
    logic   start;

    // ------------------------------------------------------------
    // decode
    assign access  = PSEL && PENABLE;
    assign cmd_wr  = access && PWRITE && (PADDR == ADDR_CMD);
    // restore needs a saved slot
    assign cmd_ok  = (PWDATA == CMD_SAVE) || ((PWDATA == CMD_RESTORE) && ckpt_valid);
    assign addr_ok = (PADDR == ADDR_CMD) || (PADDR == ADDR_FREE_COUNT) || (PADDR == ADDR_STATUS);
    assign start   = (state_q == S_IDLE) && cmd_wr && cmd_ok;

    always_comb begin
        case (PADDR)
            ADDR_FREE_COUNT: PRDATA = APB_DW'(free_count);
            ADDR_STATUS:     PRDATA = APB_DW'(ckpt_valid);
            default:         PRDATA = '0;
        endcase
    end

    // ------------------------------------------------------------
    // idle -> drain -> act -> done
    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE:  if (start) state_d = S_DRAIN;
            S_DRAIN: if (!pipe_busy) state_d = S_ACT;
            S_ACT:   state_d = S_DONE;
            default: state_d = S_IDLE;
        endcase
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            state_q      <= S_IDLE;
            op_restore_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (start) begin
                op_restore_q <= (PWDATA == CMD_RESTORE);
            end
        end
    end

    // hold from the first cycle of the command
    assign ckpt_hold    = start || (state_q != S_IDLE);
    assign ckpt_save    = (state_q == S_ACT) && !op_restore_q;
    assign ckpt_restore = (state_q == S_ACT) && op_restore_q;

    // other accesses finish at once, errors too
    assign PREADY  = ((state_q == S_IDLE) && !start) || (state_q == S_DONE);
    assign PSLVERR = (state_q == S_IDLE) && access && (!addr_ok || (cmd_wr && !cmd_ok));

    // master keeps the transfer steady through wait states
    a_apb_stable: assert property (@(posedge CLK) disable iff (!nRST)
        PSEL && PENABLE && !PREADY |=> PSEL && PENABLE
        && $stable(PWRITE) && $stable(PADDR) && $stable(PWDATA));

endmodule

// ==== rename_top.sv ====
/*
 * Register-rename block top level. Two-stage rename pipeline, commit port,
 * one checkpoint slot and the APB control slave.
 */
`timescale 1ns/1ps

module rename_top import rename_pkg::*, apb_map_pkg::*; #(
    parameter int AR_COUNT = DEF_AR_COUNT,
    parameter int PR_COUNT = DEF_PR_COUNT,
    localparam int AR_W = $clog2(AR_COUNT),
    localparam int PR_W = $clog2(PR_COUNT)
) (
    input  logic              CLK,
    input  logic              nRST,
    // rename input
    input  logic              in_valid,
    output logic              in_ready,
    input  logic [AR_W-1:0]   in_src1_ar,
    input  logic [AR_W-1:0]   in_src2_ar,
    input  logic [AR_W-1:0]   in_dest_ar,
    input  logic              in_has_dest,
    // rename output
    output logic              out_valid,
    input  logic              out_ready,
    output logic [PR_W-1:0]   out_src1_pr,
    output logic [PR_W-1:0]   out_src2_pr,
    output logic [PR_W-1:0]   out_new_pr,
    output logic [PR_W-1:0]   out_old_pr,
    output logic              out_has_dest,
    // commit
    input  logic              commit_valid,
    input  logic [PR_W-1:0]   commit_pr,
    // APB
    input  logic              PSEL,
    input  logic              PENABLE,
    input  logic              PWRITE,
    input  logic [APB_DW-1:0] PADDR,
    input  logic [APB_DW-1:0] PWDATA,
    output logic [APB_DW-1:0] PRDATA,
    output logic              PREADY,
    output logic              PSLVERR
);

    typedef logic [AR_COUNT-1:0][PR_W-1:0] map_snap_t;
    typedef logic [PR_W:0]                 head_snap_t;

    logic       ckpt_hold, ckpt_save, ckpt_restore;
    logic       alloc_busy, map_busy, pipe_busy;
    logic       map_ckpt_valid, head_ckpt_valid, ckpt_valid;
    head_snap_t free_count, head, head_ckpt;
    map_snap_t  live_map, map_ckpt;

    assign pipe_busy  = alloc_busy | map_busy;
    assign ckpt_valid = map_ckpt_valid & head_ckpt_valid;

    rename_stage_if #(.AR_COUNT(AR_COUNT), .PR_COUNT(PR_COUNT)) u_stage_if ();

    alloc_stage #(.AR_COUNT(AR_COUNT), .PR_COUNT(PR_COUNT)) u_alloc_stage (
        .CLK(CLK), .nRST(nRST),
        .in_valid(in_valid), .in_ready(in_ready), .in_src1_ar(in_src1_ar),
        .in_src2_ar(in_src2_ar), .in_dest_ar(in_dest_ar), .in_has_dest(in_has_dest),
        .hold(ckpt_hold), .flush(ckpt_restore),
        .commit_valid(commit_valid), .commit_pr(commit_pr),
        .free_count(free_count), .head(head),
        .restore_valid(ckpt_restore), .restore_head(head_ckpt),
        .st(u_stage_if.producer), .busy(alloc_busy)
    );

    map_stage #(.AR_COUNT(AR_COUNT), .PR_COUNT(PR_COUNT)) u_map_stage (
        .CLK(CLK), .nRST(nRST), .st(u_stage_if.consumer),
        .out_valid(out_valid), .out_ready(out_ready), .out_src1_pr(out_src1_pr),
        .out_src2_pr(out_src2_pr), .out_new_pr(out_new_pr), .out_old_pr(out_old_pr),
        .out_has_dest(out_has_dest), .flush(ckpt_restore), .save_map(live_map),
        .restore_valid(ckpt_restore), .restore_map(map_ckpt), .busy(map_busy)
    );

    // ------------------------------------------------------------
    // checkpoint slot, map and free-list head
    checkpoint_store #(.T(map_snap_t)) u_map_ckpt (
        .CLK(CLK), .nRST(nRST), .save(ckpt_save), .save_data(live_map),
        .data(map_ckpt), .valid(map_ckpt_valid)
    );

    checkpoint_store #(.T(head_snap_t)) u_head_ckpt (
        .CLK(CLK), .nRST(nRST), .save(ckpt_save), .save_data(head),
        .data(head_ckpt), .valid(head_ckpt_valid)
    );

    apb_ctrl #(.PR_COUNT(PR_COUNT)) u_apb_ctrl (
        .CLK(CLK), .nRST(nRST),
        .PSEL(PSEL), .PENABLE(PENABLE), .PWRITE(PWRITE), .PADDR(PADDR),
        .PWDATA(PWDATA), .PRDATA(PRDATA), .PREADY(PREADY), .PSLVERR(PSLVERR),
        .free_count(free_count), .ckpt_valid(ckpt_valid), .pipe_busy(pipe_busy),
        .ckpt_hold(ckpt_hold), .ckpt_save(ckpt_save), .ckpt_restore(ckpt_restore)
    );

endmodule

// ==== tb_rename_top.sv ====
/*
 * Testbench for the register-rename block. Drives the rename stream, commit
 * port and APB slave, tracks a queue-based model and checks with assertions.
 */
`timescale 1ns/1ps

module tb_rename_top import rename_pkg::*, apb_map_pkg::*;;

    localparam int AR_W = DEF_AR_W;
    localparam int PR_W = DEF_PR_W;
    // rough request count over all tests sets the watchdog
    localparam int N_REQ = 160;
    localparam time TIMEOUT = 200 * N_REQ * 20ns + 10us;

    typedef struct packed {
        logic [PR_W-1:0] s1, s2, newp, old;
        logic            hd;
    } exp_t;

    logic CLK, nRST;
    logic in_valid, in_ready, in_has_dest;
    logic [AR_W-1:0] in_src1_ar, in_src2_ar, in_dest_ar;
    logic out_valid, out_ready, out_has_dest;
    logic [PR_W-1:0] out_src1_pr, out_src2_pr, out_new_pr, out_old_pr;
    logic commit_valid;
    logic [PR_W-1:0] commit_pr;
    logic PSEL, PENABLE, PWRITE, PREADY, PSLVERR;
    logic [APB_DW-1:0] PADDR, PWDATA, PRDATA;

    // ------------------------------------------------------------
    // reference model state
    logic [PR_W-1:0] model_map [DEF_AR_COUNT];
    logic [PR_W-1:0] saved_map [DEF_AR_COUNT];
    logic [PR_W-1:0] free_q[$];
    logic [PR_W-1:0] saved_free[$];
    logic [PR_W-1:0] retired[$];
    exp_t exp_q[$];
    exp_t exp_front;
    logic exp_valid;
    logic rand_ready;
    int   errors, test_num, failed_tests, err_mark;

    rename_top u_rename_top (.*);

    always #10 CLK = ~CLK;

    // random back-pressure only when enabled
    always @(negedge CLK) begin
        out_ready <= rand_ready ? ($urandom % 3 != 0) : 1'b1;
    end

    // model follows the DUT's handshakes edge by edge
    always @(posedge CLK) begin
        exp_t e;
        if (nRST) begin
            if (out_valid && out_ready && exp_q.size() > 0) begin
                void'(exp_q.pop_front());
                if (out_has_dest) retired.push_back(out_old_pr);
            end
            if (in_valid && in_ready) begin
                e.s1 = model_map[in_src1_ar];
                e.s2 = model_map[in_src2_ar];
                e.old = model_map[in_dest_ar];
                e.hd = in_has_dest;
                e.newp = '0;
                if (in_has_dest) begin
                    e.newp = free_q.pop_front();
                    model_map[in_dest_ar] = e.newp;
                end
                exp_q.push_back(e);
            end
            if (commit_valid) free_q.push_back(commit_pr);
            exp_valid = (exp_q.size() > 0);
            if (exp_valid) exp_front = exp_q[0];
        end
    end

    // count a failure and report it at once
    task automatic log_error(input string msg);
        errors++;
        $display("%s", msg);
    endtask

    // ------------------------------------------------------------
    // output checks on each handshake
    a_expected: assert property (@(posedge CLK) disable iff (!nRST)
        out_valid && out_ready |-> exp_valid)
        else log_error($sformatf("%0t output accepted with nothing outstanding", $time));
    a_src1: assert property (@(posedge CLK) disable iff (!nRST)
        out_valid && out_ready |-> out_src1_pr == exp_front.s1)
        else log_error($sformatf("[ERROR] %0t out_src1_pr got %0d expected %0d",
            $time, $sampled(out_src1_pr), $sampled(exp_front.s1)));
    a_src2: assert property (@(posedge CLK) disable iff (!nRST)
        out_valid && out_ready |-> out_src2_pr == exp_front.s2)
        else log_error($sformatf("[ERROR] %0t out_src2_pr got %0d expected %0d",
            $time, $sampled(out_src2_pr), $sampled(exp_front.s2)));
    a_old: assert property (@(posedge CLK) disable iff (!nRST)
        out_valid && out_ready |-> out_old_pr == exp_front.old)
        else log_error($sformatf("[ERROR] %0t out_old_pr got %0d expected %0d",
            $time, $sampled(out_old_pr), $sampled(exp_front.old)));
    a_hd: assert property (@(posedge CLK) disable iff (!nRST)
        out_valid && out_ready |-> out_has_dest == exp_front.hd)
        else log_error($sformatf("[ERROR] %0t out_has_dest got %0d expected %0d",
            $time, $sampled(out_has_dest), $sampled(exp_front.hd)));
    a_new: assert property (@(posedge CLK) disable iff (!nRST)
        out_valid && out_ready && out_has_dest |-> out_new_pr == exp_front.newp)
        else log_error($sformatf("[ERROR] %0t out_new_pr got %0d expected %0d",
            $time, $sampled(out_new_pr), $sampled(exp_front.newp)));
    // stalled output must not move
    a_stable: assert property (@(posedge CLK) disable iff (!nRST)
        out_valid && !out_ready |=> $stable({out_src1_pr, out_src2_pr, out_new_pr,
        out_old_pr, out_has_dest}))
        else log_error($sformatf("%0t held output changed while stalled", $time));

    // ------------------------------------------------------------
    // stimulus tasks are entered on a falling edge
    task automatic send_req(input logic [AR_W-1:0] s1, s2, d, input logic hd);
        int n;
        logic got;
        n = 0;
        got = 1'b0;
        in_valid = 1'b1;
        in_src1_ar = s1;
        in_src2_ar = s2;
        in_dest_ar = d;
        in_has_dest = hd;
        while (!got && n < 1000) begin
            #5 got = in_ready;
            @(negedge CLK);
            n++;
        end
        if (!got) begin
            log_error($sformatf("%0t request never accepted", $time));
        end
        in_valid = 1'b0;
    endtask

    task automatic drain();
        int n;
        n = 0;
        while ((exp_q.size() > 0 || out_valid) && n < 2000) begin
            @(negedge CLK);
            n++;
        end
        if (n >= 2000) begin
            log_error($sformatf("%0t pipeline did not drain", $time));
        end
    endtask

    task automatic apb_xfer(input logic wr, input logic [APB_DW-1:0] addr, data,
                            output logic [APB_DW-1:0] rdata, output logic err);
        logic rdy;
        int   n;
        rdy = 1'b0;
        n = 0;
        PSEL = 1'b1;
        PWRITE = wr;
        PADDR = addr;
        PWDATA = data;
        @(negedge CLK);
        PENABLE = 1'b1;
        while (!rdy && n < 1000) begin
            // sample the response a quarter period before the edge
            #5 rdy = PREADY;
            rdata = PRDATA;
            err = PSLVERR;
            @(negedge CLK);
            n++;
        end
        if (!rdy) begin
            log_error($sformatf("%0t APB transfer never completed", $time));
        end else if (!wr && n > 1) begin
            log_error($sformatf("%0t APB read took %0d wait states", $time, n - 1));
        end
        PSEL = 1'b0;
        PENABLE = 1'b0;
    endtask

    task automatic expect_err(input logic err, exp_err);
        assert (err == exp_err) else
            log_error($sformatf("[ERROR] %0t PSLVERR got %0d expected %0d",
                $time, err, exp_err));
    endtask

    task automatic check_apb(input logic [APB_DW-1:0] got, exp, input logic err, exp_err);
        assert (got == exp) else
            log_error($sformatf("[ERROR] %0t PRDATA got %0d expected %0d", $time, got, exp));
        expect_err(err, exp_err);
    endtask

    task automatic end_test(input string name);
        test_num++;
        if (errors != err_mark) failed_tests++;
        $display("test %0d %s: %s", test_num, name, (errors == err_mark) ? "ok" : "errors");
        err_mark = errors;
    endtask

    initial begin
        #(TIMEOUT);
        $display("watchdog expired, run stopped");
        $display("Testbench failed");
        $finish;
    end

    initial begin
        logic [APB_DW-1:0] rd;
        logic err;
        void'($urandom(32'h0fba_9726));
        CLK = 1'b0;
        nRST = 1'b0;
        in_valid = 1'b0;
        in_has_dest = 1'b0;
        in_src1_ar = '0;
        in_src2_ar = '0;
        in_dest_ar = '0;
        out_ready = 1'b1;
        commit_valid = 1'b0;
        commit_pr = '0;
        PSEL = 1'b0;
        PENABLE = 1'b0;
        PWRITE = 1'b0;
        PADDR = '0;
        PWDATA = '0;
        rand_ready = 1'b0;
        errors = 0;
        test_num = 0;
        failed_tests = 0;
        err_mark = 0;
        exp_valid = 1'b0;
        // model after reset has identity map and PRs 32..63 free
        for (int i = 0; i < DEF_AR_COUNT; i++) model_map[i] = PR_W'(i);
        for (int i = DEF_AR_COUNT; i < DEF_PR_COUNT; i++) free_q.push_back(PR_W'(i));
        repeat (8) @(posedge CLK);
        @(negedge CLK);
        nRST = 1'b1;
        @(negedge CLK);

        // identity reads with no destinations written
        repeat (8) send_req(AR_W'($urandom), AR_W'($urandom), AR_W'($urandom), 1'b0);
        drain();
        end_test("identity after reset");

        // dependent chain on one register
        for (int i = 0; i < 6; i++) send_req(5'd5, AR_W'(i), 5'd5, 1'b1);
        drain();
        end_test("allocation order and dependencies");

        rand_ready = 1'b1;
        for (int i = 0; i < 40; i++) begin
            send_req(AR_W'($urandom), AR_W'($urandom), AR_W'($urandom),
                     ($urandom % 2 == 1) && (free_q.size() > 2));
        end
        drain();
        rand_ready = 1'b0;
        end_test("random back-pressure");

        apb_xfer(1'b0, ADDR_FREE_COUNT, '0, rd, err);
        check_apb(rd, APB_DW'(free_q.size()), err, 1'b0);
        while (free_q.size() > 0) begin
            send_req(AR_W'($urandom), AR_W'($urandom), AR_W'($urandom), 1'b1);
        end
        drain();
        apb_xfer(1'b0, ADDR_FREE_COUNT, '0, rd, err);
        check_apb(rd, 0, err, 1'b0);
        // an empty list must block a request with a destination
        in_valid = 1'b1;
        in_has_dest = 1'b1;
        repeat (5) begin
            #5 assert (!in_ready) else
                log_error($sformatf("[ERROR] %0t in_ready got %0b expected 0",
                    $time, in_ready));
            @(negedge CLK);
        end
        commit_valid = 1'b1;
        commit_pr = retired.pop_front();
        @(negedge CLK);
        commit_valid = 1'b0;
        send_req(in_src1_ar, in_src2_ar, in_dest_ar, 1'b1);
        repeat (16) begin
            commit_valid = 1'b1;
            commit_pr = retired.pop_front();
            @(negedge CLK);
        end
        commit_valid = 1'b0;
        drain();
        apb_xfer(1'b0, ADDR_FREE_COUNT, '0, rd, err);
        check_apb(rd, APB_DW'(free_q.size()), err, 1'b0);
        end_test("free count and exhaustion");

        // error paths before any save
        apb_xfer(1'b1, ADDR_CMD, CMD_RESTORE, rd, err);
        expect_err(err, 1'b1);
        apb_xfer(1'b0, 32'hC, '0, rd, err);
        expect_err(err, 1'b1);
        apb_xfer(1'b0, ADDR_STATUS, '0, rd, err);
        check_apb(rd, 0, err, 1'b0);
        apb_xfer(1'b1, ADDR_CMD, CMD_SAVE, rd, err);
        expect_err(err, 1'b0);
        saved_map = model_map;
        saved_free = free_q;
        apb_xfer(1'b0, ADDR_STATUS, '0, rd, err);
        check_apb(rd, 1, err, 1'b0);
        repeat (5) send_req(AR_W'($urandom), AR_W'($urandom), AR_W'($urandom), 1'b1);
        drain();
        apb_xfer(1'b1, ADDR_CMD, CMD_RESTORE, rd, err);
        expect_err(err, 1'b0);
        model_map = saved_map;
        free_q = saved_free;
        apb_xfer(1'b0, ADDR_FREE_COUNT, '0, rd, err);
        check_apb(rd, APB_DW'(free_q.size()), err, 1'b0);
        // reads now see the saved map and the next PR comes from the saved head
        for (int i = 0; i < 8; i++) send_req(AR_W'(i), AR_W'(i + 8), AR_W'(i + 16), i == 7);
        drain();
        end_test("checkpoint save and restore");

        $display("tests %0d, failed %0d, errors %0d", test_num, failed_tests, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// ==== list.f ====
rename_pkg.sv
apb_map_pkg.sv
rename_stage_if.sv
free_list.sv
map_table.sv
checkpoint_store.sv
alloc_stage.sv
map_stage.sv
apb_ctrl.sv
rename_top.sv
tb_rename_top.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the rename testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_rename_top -f list.f
out=$(./obj_dir/Vtb_rename_top)
echo "$out"

if echo "$out" | grep -qx "Testbench passed"; then
    exit 0
fi
exit 1
